// File: Makefile
# Verilator build for the channel multiplexer testbench.

VERILATOR ?= verilator
TOP       := chmux_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 -Mdir $(OBJ_DIR) --top-module $(TOP)
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list.
compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# A failing check ends in $$fatal, which gives a nonzero exit status.
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
+incdir+include
rtl/chmux_pkg.sv
rtl/chmux_route_table.sv
rtl/chmux_crossbar.sv
rtl/chmux_beat_counter.sv
rtl/chmux_top.sv
tb/chmux_assert.sv
tb/chmux_tb.sv

// File: include/chmux_macros.svh
// Size macros for the channel multiplexer.
// Channel counts, sample sizes, index widths and counter width.

`ifndef CHMUX_MACROS_SVH
`define CHMUX_MACROS_SVH

// Samples carried by one beat and the width of each sample.
`define CHMUX_PARALLEL_SAMPLES 4
`define CHMUX_SAMPLE_WIDTH 16

// Six inputs leave select codes 6 and 7 unused, and those disable an output.
`define CHMUX_IN_CHANNELS 6
`define CHMUX_OUT_CHANNELS 4

// Width of a source index and of an output index.
`define CHMUX_SELECT_BITS 3
`define CHMUX_OUT_INDEX_BITS 2

// Width of the per-output beat counters.
`define CHMUX_COUNT_WIDTH 16

`endif

// File: rtl/chmux_beat_counter.sv
// Per-output beat counters of the channel multiplexer.
// One wrapping counter per output, counting forwarded beats since reset.

`default_nettype none
`timescale 1ns/1ps

`include "chmux_macros.svh"

module chmux_beat_counter
  import chmux_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset,
  input  logic [`CHMUX_OUT_CHANNELS-1:0] out_valid,
  output count_array_t                   beat_counts
);

  count_array_t next_counts;

  // A counter steps once per valid output beat and wraps at full scale.
  always_comb begin
    for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
      if (out_valid[o]) begin
        next_counts[o] = beat_counts[o] + 1'b1;
      end else begin
        next_counts[o] = beat_counts[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      beat_counts <= '0;
    end else begin
      beat_counts <= next_counts;
    end
  end

endmodule

`default_nettype wire

// File: rtl/chmux_crossbar.sv
// Registered crossbar of the channel multiplexer.
// Each output takes the beat and valid of its routed input, gated by the
// route enable, with one cycle of latency.

`default_nettype none
`timescale 1ns/1ps

`include "chmux_macros.svh"

module chmux_crossbar
  import chmux_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  route_table_t routes,
  input  in_bundle_t   data_in,
  output out_bundle_t  data_out
);

  logic [`CHMUX_OUT_CHANNELS-1:0] next_valid;
  beat_t [`CHMUX_OUT_CHANNELS-1:0] sel_data;

  // Selection for every output in parallel.
  // The enable comes from the route table and is trusted here. A disabled
  // route points at input zero, which is always in range.
  always_comb begin
    for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
      sel_data[o] = data_in.data[routes[o].source];
      next_valid[o] = routes[o].enable & data_in.valid[routes[o].source];
    end
  end

  // Valid is registered every cycle; data only loads on a forwarded beat
  // and otherwise holds its last value.
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out.valid <= '0;
      data_out.data <= '0;
    end else begin
      data_out.valid <= next_valid;
      for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
        if (next_valid[o]) begin
          data_out.data[o] <= sel_data[o];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/chmux_pkg.sv
// Types shared by the channel multiplexer.
// Beats, channel bundles, route entries, config words and counters.

`default_nettype none

`include "chmux_macros.svh"

package chmux_pkg;

  // One beat of parallel samples from a single channel.
  typedef logic [`CHMUX_PARALLEL_SAMPLES-1:0][`CHMUX_SAMPLE_WIDTH-1:0] beat_t;

  typedef struct packed {
    logic [`CHMUX_IN_CHANNELS-1:0] valid;
    beat_t [`CHMUX_IN_CHANNELS-1:0] data;
  } in_bundle_t;

  typedef struct packed {
    logic [`CHMUX_OUT_CHANNELS-1:0] valid;
    beat_t [`CHMUX_OUT_CHANNELS-1:0] data;
  } out_bundle_t;

  // Routing for one output. A disabled entry always holds source zero.
  typedef struct packed {
    logic enable;
    logic [`CHMUX_SELECT_BITS-1:0] source;
  } route_t;

  typedef route_t [`CHMUX_OUT_CHANNELS-1:0] route_table_t;

  typedef logic [`CHMUX_OUT_CHANNELS-1:0][`CHMUX_SELECT_BITS-1:0] select_map_t;

  typedef struct packed {
    logic [`CHMUX_OUT_INDEX_BITS-1:0] out_index;
    logic [`CHMUX_SELECT_BITS-1:0] source;
    logic [`CHMUX_OUT_CHANNELS*`CHMUX_SELECT_BITS-`CHMUX_OUT_INDEX_BITS
           -`CHMUX_SELECT_BITS-1:0] pad;
  } single_route_t;

  // The payload is read as a full map or as a single update, by kind.
  typedef union packed {
    select_map_t full_map;
    single_route_t single;
  } config_payload_u;

  typedef enum logic {
    cfg_full_map,
    cfg_single
  } config_kind_e;

  typedef struct packed {
    config_kind_e kind;
    config_payload_u payload;
  } config_word_t;

  typedef logic [`CHMUX_OUT_CHANNELS-1:0][`CHMUX_COUNT_WIDTH-1:0] count_array_t;

endpackage

`default_nettype wire

// File: rtl/chmux_route_table.sv
// Route table of the channel multiplexer.
// Decodes config words, range-checks source indices and holds the
// registered route for each output.

`default_nettype none
`timescale 1ns/1ps

`include "chmux_macros.svh"

module chmux_route_table
  import chmux_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         config_valid,
  input  config_word_t config_data,
  output route_table_t routes
);

  route_table_t next_routes;

  // Turns a requested source index into a route entry. Codes past the last
  // input channel give a disabled route with source zero.
  function automatic route_t check_source(input logic [`CHMUX_SELECT_BITS-1:0] src);
    route_t entry;
    if (src < `CHMUX_IN_CHANNELS) begin
      entry.enable = 1'b1;
      entry.source = src;
    end else begin
      entry.enable = 1'b0;
      entry.source = '0;
    end
    return entry;
  endfunction

  always_comb begin
    next_routes = routes;
    case (config_data.kind)
      cfg_full_map: begin
        for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
          next_routes[o] = check_source(config_data.payload.full_map[o]);
        end
      end
      cfg_single: begin
        // Only the named output is touched; all other entries keep their value.
        next_routes[config_data.payload.single.out_index] =
          check_source(config_data.payload.single.source);
      end
    endcase
  end

  // The new table is visible right after the strobe edge, so it governs
  // input beats from the following edge on.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
        routes[o].enable <= 1'b0;
        routes[o].source <= '0;
      end
    end else if (config_valid) begin
      routes <= next_routes;
    end
  end

endmodule

`default_nettype wire

// File: rtl/chmux_top.sv
// Top level of the channel multiplexer.
// Connects the route table, the crossbar and the beat counters.
// Latency is one cycle to data_out and two cycles to beat_counts.

`default_nettype none
`timescale 1ns/1ps

`include "chmux_macros.svh"

module chmux_top
  import chmux_pkg::*;
(
  input  logic         clk,
  input  logic         reset,

  // Parallel-sample input channels, one strobe per beat.
  input  in_bundle_t   data_in,

  // Config port, sampled on the strobe.
  input  logic         config_valid,
  input  config_word_t config_data,

  // Routed output channels and status.
  output out_bundle_t  data_out,
  output route_table_t routes,
  output count_array_t beat_counts
);

  route_table_t route_table;
  out_bundle_t  routed_out;
  logic [`CHMUX_OUT_CHANNELS-1:0] routed_valid;

  assign routed_valid = routed_out.valid;

  chmux_route_table chmux_route_table_i (
    .clk          (clk),
    .reset        (reset),
    .config_valid (config_valid),
    .config_data  (config_data),
    .routes       (route_table)
  );

  chmux_crossbar chmux_crossbar_i (
    .clk      (clk),
    .reset    (reset),
    .routes   (route_table),
    .data_in  (data_in),
    .data_out (routed_out)
  );

  // Counters see the registered output valids, adding the second cycle.
  chmux_beat_counter chmux_beat_counter_i (
    .clk         (clk),
    .reset       (reset),
    .out_valid   (routed_valid),
    .beat_counts (beat_counts)
  );

  assign data_out = routed_out;
  assign routes = route_table;

endmodule

`default_nettype wire

// File: tb/chmux_assert.sv
// Concurrent assertions on the channel multiplexer outputs.
// Attached to chmux_top by bind.

`default_nettype none
`timescale 1ns/1ps

`include "chmux_macros.svh"

module chmux_assert
  import chmux_pkg::*;
(
  input logic         clk,
  input logic         reset,
  input out_bundle_t  data_out,
  input route_table_t routes
);

  // Number of assertion failures so far.
  int failures = 0;

  // Any edge taken in reset leaves every output valid low.
  assert property (@(posedge clk) reset |=> (data_out.valid == '0))
    else begin
      $error("output valid bits not cleared by reset");
      failures++;
    end

  for (genvar o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin : g_out

    // The valid seen now was formed with the route in force one edge earlier.
    assert property (@(posedge clk) disable iff (reset)
                     data_out.valid[o] |-> $past(routes[o].enable))
      else begin
        $error("output %0d valid while its route was disabled", o);
        failures++;
      end

    assert property (@(posedge clk) disable iff (reset)
                     !routes[o].enable |-> (routes[o].source == '0))
      else begin
        $error("disabled route %0d holds a nonzero source", o);
        failures++;
      end

  end

endmodule

bind chmux_top chmux_assert chmux_assert_i (
  .clk      (clk),
  .reset    (reset),
  .data_out (data_out),
  .routes   (routes)
);

`default_nettype wire

// File: tb/chmux_tb.sv
// Testbench for the channel multiplexer.
// Random beats and config strobes, a reference route model, and a
// compare process that checks every output on every clock edge.

`default_nettype none
`timescale 1ns/1ps

`include "chmux_macros.svh"

module chmux_tb
  import chmux_pkg::*;
;

  localparam int DRAIN_LIMIT = 20;

  logic         clk;
  logic         reset;
  in_bundle_t   data_in;
  logic         config_valid;
  config_word_t config_data;
  out_bundle_t  data_out;
  route_table_t routes;
  count_array_t beat_counts;

  integer       seed;

  // Model state, updated at each rising edge by the compare process.
  route_table_t model_routes;
  out_bundle_t  exp_out;
  count_array_t model_counts;

  chmux_top chmux_top_i (
    .clk          (clk),
    .reset        (reset),
    .data_in      (data_in),
    .config_valid (config_valid),
    .config_data  (config_data),
    .data_out     (data_out),
    .routes       (routes),
    .beat_counts  (beat_counts)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Applies one config word to a route table. Source codes past the last
  // input channel disable the output and clear its source.
  function automatic route_table_t apply_config(input route_table_t cur,
                                                input config_word_t cfg);
    route_table_t nxt;
    logic [`CHMUX_SELECT_BITS-1:0] src;
    nxt = cur;
    if (cfg.kind == cfg_full_map) begin
      for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
        src = cfg.payload.full_map[o];
        nxt[o].enable = (src < `CHMUX_IN_CHANNELS);
        nxt[o].source = (src < `CHMUX_IN_CHANNELS) ? src : '0;
      end
    end else begin
      src = cfg.payload.single.source;
      nxt[cfg.payload.single.out_index].enable = (src < `CHMUX_IN_CHANNELS);
      nxt[cfg.payload.single.out_index].source = (src < `CHMUX_IN_CHANNELS) ? src : '0;
    end
    return nxt;
  endfunction

  function automatic config_word_t full_map_word(input select_map_t map);
    config_word_t cfg;
    cfg.kind = cfg_full_map;
    cfg.payload.full_map = map;
    return cfg;
  endfunction

  function automatic config_word_t single_word(input logic [`CHMUX_OUT_INDEX_BITS-1:0] out_idx,
                                               input logic [`CHMUX_SELECT_BITS-1:0] src);
    config_word_t cfg;
    cfg.kind = cfg_single;
    cfg.payload = '0;
    cfg.payload.single.out_index = out_idx;
    cfg.payload.single.source = src;
    return cfg;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "simulation stopped after a failure");
  endtask

  task automatic check_bundle(input out_bundle_t got, input out_bundle_t exp,
                              input string name);
    if (got !== exp) begin
      $display("ERR t=%0t %s expected %h received %h", $time, name, exp, got);
      stop_with_failure({"Mismatch on ", name});
    end
  endtask

  task automatic check_routes(input route_table_t got, input route_table_t exp,
                              input string name);
    if (got !== exp) begin
      $display("ERR t=%0t %s expected %h received %h", $time, name, exp, got);
      stop_with_failure({"Mismatch on ", name});
    end
  endtask

  task automatic check_counts(input count_array_t got, input count_array_t exp,
                              input string name);
    if (got !== exp) begin
      $display("ERR t=%0t %s expected %h received %h", $time, name, exp, got);
      stop_with_failure({"Mismatch on ", name});
    end
  endtask

  // New random beats and valid pattern on every input channel.
  task automatic randomize_inputs();
    in_bundle_t b;
    logic [31:0] rnd;
    for (int i = 0; i < `CHMUX_IN_CHANNELS; i++) begin
      b.data[i] = {$random(seed), $random(seed)};
    end
    rnd = $random(seed);
    b.valid = rnd[`CHMUX_IN_CHANNELS-1:0];
    data_in = b;
  endtask

  task automatic random_beats(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge clk);
      config_valid = 1'b0;
      randomize_inputs();
    end
  endtask

  // The strobe cycle carries random beats too, so data keeps flowing.
  task automatic send_config(input config_word_t cfg);
    @(negedge clk);
    config_valid = 1'b1;
    config_data = cfg;
    randomize_inputs();
    @(negedge clk);
    config_valid = 1'b0;
    randomize_inputs();
  endtask

  task automatic single_update_check(input logic [`CHMUX_OUT_INDEX_BITS-1:0] out_idx,
                                     input logic [`CHMUX_SELECT_BITS-1:0] src);
    route_table_t saved;
    @(negedge clk);
    saved = routes;
    send_config(single_word(out_idx, src));
    check_routes(routes, apply_config(saved, single_word(out_idx, src)),
                 "routes after single update");
  endtask

  // Stops the inputs, waits until the outputs have been idle for two
  // cycles, then compares the counters with the model.
  task automatic drain_and_check(input string phase);
    int idle_cycles;
    int waited;
    idle_cycles = 0;
    waited = 0;
    while (idle_cycles < 2) begin
      @(negedge clk);
      config_valid = 1'b0;
      data_in.valid = '0;
      waited++;
      if (data_out.valid == '0) begin
        idle_cycles++;
      end else begin
        idle_cycles = 0;
      end
      if (waited > DRAIN_LIMIT) begin
        stop_with_failure({"Timeout: outputs never went idle after phase ", phase});
      end
    end
    check_counts(beat_counts, model_counts, {"beat_counts after ", phase});
  endtask

  initial begin : compare_outputs
    logic [`CHMUX_SELECT_BITS-1:0] src;
    forever begin
      @(posedge clk);
      if (reset) begin
        model_routes = '0;
        exp_out = '0;
        model_counts = '0;
      end else begin
        for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
          if (exp_out.valid[o]) begin
            model_counts[o] = model_counts[o] + 1'b1;
          end
        end
        // Beats at this edge follow the routes held before any strobe here.
        for (int o = 0; o < `CHMUX_OUT_CHANNELS; o++) begin
          src = model_routes[o].source;
          if (model_routes[o].enable && data_in.valid[src]) begin
            exp_out.valid[o] = 1'b1;
            exp_out.data[o] = data_in.data[src];
          end else begin
            exp_out.valid[o] = 1'b0;
          end
        end
        if (config_valid) begin
          model_routes = apply_config(model_routes, config_data);
        end
      end
      #1;
      check_bundle(data_out, exp_out, "data_out");
      check_routes(routes, model_routes, "routes");
      check_counts(beat_counts, model_counts, "beat_counts");
      if (chmux_top_i.chmux_assert_i.failures != 0) begin
        stop_with_failure("An assertion on the DUT outputs failed");
      end
    end
  end

  initial begin : stimulus
    logic [31:0] rnd;
    seed = 32'h28b8;
    reset = 1'b1;
    data_in = '0;
    config_valid = 1'b0;
    config_data = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_routes(routes, '0, "routes after reset");
    check_bundle(data_out, '0, "data_out after reset");
    check_counts(beat_counts, '0, "beat_counts after reset");
    random_beats(20);
    drain_and_check("reset idle");

    // Outputs 1 and 3 share input 2.
    send_config(full_map_word({3'd2, 3'd5, 3'd2, 3'd0}));
    random_beats(40);
    drain_and_check("first full map");
    send_config(full_map_word({3'd4, 3'd4, 3'd4, 3'd1}));
    random_beats(30);
    drain_and_check("second full map");

    single_update_check(2'd1, 3'd3);
    random_beats(10);
    single_update_check(2'd3, 3'd5);
    random_beats(10);
    single_update_check(2'd0, 3'd2);
    random_beats(10);
    drain_and_check("single updates");

    send_config(full_map_word({3'd7, 3'd1, 3'd6, 3'd3}));
    random_beats(30);
    drain_and_check("out of range full map");
    single_update_check(2'd2, 3'd0);
    single_update_check(2'd0, 3'd7);
    single_update_check(2'd2, 3'd6);
    random_beats(30);
    drain_and_check("out of range single updates");

    // Rerouting while beats keep arriving on every cycle.
    for (int n = 0; n < 12; n++) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        send_config(full_map_word(rnd[12:1]));
      end else begin
        send_config(single_word(rnd[14:13], rnd[17:15]));
      end
      random_beats(3 + int'(rnd[19:18]));
    end
    drain_and_check("config during traffic");

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
